// ==== list.f ====
rtl/issue_pkg.sv
rtl/inst_queue.sv
rtl/inst_decode.sv
rtl/issue_ctrl.sv
rtl/issue_reg.sv
rtl/issue_top.sv
test/issue_properties.sv
test/tb_issue.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -f list.f --top-module tb_issue
out="$(./obj_dir/Vtb_issue || true)"
echo "$out"
if echo "$out" | grep -q "Simulation finished: PASS"; then
    exit 0
else
    exit 1
fi

// ==== test/tb_issue.sv ====
module tb_issue import issue_pkg::*; ();
    timeunit 1ns;
    timeprecision 100ps;

    typedef struct packed {
        logic [31:0] pc;
        logic [31:0] inst;
        logic [4:0]  wdst;
        logic        solo;
        logic        jmp;
        logic [1:0]  tlb;
        logic        ri;
        logic        refill;
        logic        invalid;
    } entry_t;

    typedef struct {
        int i1;
        int i2;
        bit ds1;
        bit ds2;
        bit rf;
    } group_t;

    logic clk, rst, stall, flush, push, full;
    logic [31:0] push_pc, push_inst, push_pred_target;
    logic push_pred_taken, push_refill, push_invalid;
    logic out_valid_1, out_w_ena_1, out_in_ds_1, out_refetch_1;
    logic out_valid_2, out_w_ena_2, out_in_ds_2, out_refetch_2;
    logic [31:0] out_pc_1, out_inst_1, out_pc_2, out_inst_2;
    logic [4:0] out_w_dst_1, out_w_dst_2;
    logic [2:0] out_exc_1, out_exc_2;

    entry_t tbl[$];
    group_t exp_q[$];
    logic [31:0] lfsr = 32'h920e;
    int cycles = 0;
    int cycle_limit = 1000;
    // queue entries pushed and not yet issued
    int occupancy = 0;
    logic updated = 1'b0;
    logic prev_v1, prev_v2;
    logic [31:0] prev_pc1, prev_pc2;

    issue_top UUT (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    function automatic logic take_bit();
        lfsr = {1'b0, lfsr[31:1]} ^ (lfsr[0] ? 32'ha300_0000 : 32'h0);
        return lfsr[0];
    endfunction

    function automatic logic [31:0] enc_r(logic [4:0] rs, logic [4:0] rt, logic [4:0] rd,
                                          logic [5:0] fn);
        return {op_special, rs, rt, rd, 5'd0, fn};
    endfunction

    function automatic logic [31:0] enc_i(logic [5:0] op, logic [4:0] rs, logic [4:0] rt,
                                          logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    // address error first, then refill, invalid and reserved
    function automatic logic [2:0] exc_of(entry_t e);
        if (e.pc[1:0] != 2'b00) return exc_adel;
        if (e.refill) return exc_tlb_refill;
        if (e.invalid) return exc_tlb_invalid;
        if (e.ri) return exc_ri;
        return exc_none;
    endfunction

    task automatic add(logic [31:0] pc, logic [31:0] inst, logic [4:0] wdst, logic solo,
                       logic jmp, logic [1:0] tlb, logic ri, logic refill, logic invalid);
        tbl.push_back('{pc, inst, wdst, solo, jmp, tlb, ri, refill, invalid});
    endtask

    task automatic abort_run(string msg);
        $display("%s", msg);
        $display("Simulation finished: FAIL");
        $fatal(1);
    endtask

    task automatic check_value(string name, logic [31:0] exp, logic [31:0] act);
        if (exp !== act) begin
            $display("ERR %s expected %h actual %h", name, exp, act);
            $display("Simulation finished: FAIL");
            $fatal(1);
        end
    endtask

    task automatic check_slot(string tag, int idx, bit ds, bit rf, logic [31:0] pc,
                              logic [31:0] inst, logic w_ena, logic [4:0] w_dst,
                              logic in_ds, logic [2:0] exc, logic refetch);
        entry_t e;
        e = tbl[idx];
        check_value({tag, " pc"}, e.pc, pc);
        check_value({tag, " inst"}, e.inst, inst);
        check_value({tag, " w_ena"}, 32'(e.wdst != 5'd0), 32'(w_ena));
        if (e.wdst != 5'd0) check_value({tag, " w_dst"}, 32'(e.wdst), 32'(w_dst));
        check_value({tag, " in_ds"}, 32'(ds), 32'(in_ds));
        check_value({tag, " exc"}, 32'(exc_of(e)), 32'(exc));
        check_value({tag, " refetch"}, 32'(rf), 32'(refetch));
    endtask

    // the last entry stays queued when it has no partner
    task automatic build_expected(int lo, int hi);
        int i;
        bit ds, rf, blk, raw;
        entry_t e1, e2;
        ds = 0;
        rf = 0;
        i = lo;
        while (i + 1 <= hi) begin
            e1 = tbl[i];
            e2 = tbl[i+1];
            raw = (e1.wdst != 5'd0)
                && (e1.wdst == e2.inst[25:21] || e1.wdst == e2.inst[20:16]);
            blk = ds || raw || e2.solo || e2.jmp || e1.tlb != 2'd0 || exc_of(e2) != exc_none;
            exp_q.push_back('{i, blk ? -1 : i + 1, ds, e1.jmp, rf});
            ds = ds ? 1'b0 : (e1.jmp && blk);
            if (e1.tlb == 2'd2) rf = 1;
            i += blk ? 1 : 2;
        end
    endtask

    task automatic run_phase(int lo, int hi);
        int idx;
        build_expected(lo, hi);
        idx = lo;
        while (idx <= hi || exp_q.size() != 0) begin
            @(posedge clk);
            #2;
            stall = take_bit() & take_bit();
            push = 1'b0;
            if (idx <= hi && !full) begin
                push = 1'b1;
                push_pc = tbl[idx].pc;
                push_inst = tbl[idx].inst;
                push_refill = tbl[idx].refill;
                push_invalid = tbl[idx].invalid;
                idx++;
            end
        end
        @(posedge clk);
        #2;
        stall = 1'b0;
        push = 1'b0;
        flush = 1'b1;
        @(posedge clk);
        #2;
        flush = 1'b0;
        check_value("valid_1 after flush", 32'(0), 32'(out_valid_1));
        check_value("valid_2 after flush", 32'(0), 32'(out_valid_2));
    endtask

    always @(posedge clk) begin
        updated <= !stall;
        if (rst || flush) begin
            occupancy = 0;
        end else if (push) begin
            occupancy++;
        end
        cycles++;
        if (cycles > cycle_limit) begin
            $display("timeout: issue sequence did not finish in %0d cycles", cycle_limit);
            $display("Simulation finished: FAIL");
            $fatal(1);
        end
    end

    always @(negedge clk) begin
        group_t g;
        if (!rst) begin
            if (updated) begin
                if (out_valid_2 && !out_valid_1) abort_run("slot 2 valid without slot 1");
                if (out_valid_1) begin
                    if (exp_q.size() == 0) abort_run("issue output with nothing expected");
                    g = exp_q.pop_front();
                    occupancy -= out_valid_2 ? 2 : 1;
                    check_value("valid_2", 32'(g.i2 >= 0), 32'(out_valid_2));
                    check_slot("slot1", g.i1, g.ds1, g.rf, out_pc_1, out_inst_1, out_w_ena_1,
                               out_w_dst_1, out_in_ds_1, out_exc_1, out_refetch_1);
                    if (g.i2 >= 0)
                        check_slot("slot2", g.i2, g.ds2, g.rf, out_pc_2, out_inst_2,
                                   out_w_ena_2, out_w_dst_2, out_in_ds_2, out_exc_2,
                                   out_refetch_2);
                end
            end else begin
                check_value("hold valid_1", 32'(prev_v1), 32'(out_valid_1));
                check_value("hold valid_2", 32'(prev_v2), 32'(out_valid_2));
                check_value("hold pc_1", prev_pc1, out_pc_1);
                check_value("hold pc_2", prev_pc2, out_pc_2);
            end
            check_value("full", 32'(occupancy == queue_depth), 32'(full));
        end
        prev_v1 = out_valid_1;
        prev_v2 = out_valid_2;
        prev_pc1 = out_pc_1;
        prev_pc2 = out_pc_2;
    end

    initial begin
        rst = 1'b1;
        stall = 1'b0;
        flush = 1'b0;
        push = 1'b0;
        push_pc = '0;
        push_inst = '0;
        push_pred_taken = 1'b0;
        push_pred_target = '0;
        push_refill = 1'b0;
        push_invalid = 1'b0;

        // pc, inst, wdst, solo, jmp, tlb, ri, refill, invalid
        add(32'h100, enc_r(5'd1, 5'd2, 5'd3, fn_addu), 5'd3, 0, 0, 2'd0, 0, 0, 0);
        add(32'h104, enc_i(op_addiu, 5'd5, 5'd4, 16'd1), 5'd4, 0, 0, 2'd0, 0, 0, 0);
        add(32'h108, enc_r(5'd1, 5'd2, 5'd6, fn_addu), 5'd6, 0, 0, 2'd0, 0, 0, 0);
        add(32'h10c, enc_r(5'd6, 5'd1, 5'd7, fn_subu), 5'd7, 0, 0, 2'd0, 0, 0, 0);
        add(32'h110, enc_i(op_lw, 5'd9, 5'd8, 16'd0), 5'd8, 1, 0, 2'd0, 0, 0, 0);
        add(32'h114, enc_r(5'd1, 5'd2, 5'd10, fn_addu), 5'd10, 0, 0, 2'd0, 0, 0, 0);
        add(32'h118, enc_r(5'd1, 5'd2, 5'd0, fn_mult), 5'd0, 1, 0, 2'd0, 0, 0, 0);
        add(32'h11c, enc_i(op_beq, 5'd1, 5'd2, 16'd4), 5'd0, 0, 1, 2'd0, 0, 0, 0);
        add(32'h120, enc_r(5'd1, 5'd2, 5'd11, fn_addu), 5'd11, 0, 0, 2'd0, 0, 0, 0);
        add(32'h124, {op_j, 26'h40}, 5'd0, 0, 1, 2'd0, 0, 0, 0);
        add(32'h128, enc_i(op_lw, 5'd9, 5'd12, 16'd4), 5'd12, 1, 0, 2'd0, 0, 0, 0);
        add(32'h12c, enc_r(5'd1, 5'd2, 5'd13, fn_addu), 5'd13, 0, 0, 2'd0, 0, 0, 0);
        add(32'h130, 32'hfc00_0000, 5'd0, 1, 0, 2'd0, 1, 0, 0);
        add(32'h136, enc_r(5'd1, 5'd2, 5'd14, fn_addu), 5'd14, 0, 0, 2'd0, 0, 0, 0);
        add(32'h138, enc_r(5'd1, 5'd2, 5'd15, fn_addu), 5'd15, 0, 0, 2'd0, 0, 1, 1);
        add(32'h13c, enc_r(5'd1, 5'd2, 5'd16, fn_addu), 5'd16, 0, 0, 2'd0, 0, 0, 1);
        add(32'h140, 32'hfc00_0000, 5'd0, 1, 0, 2'd0, 1, 0, 1);
        add(32'h144, {op_cop0, 1'b1, 19'd0, fn_tlbwi}, 5'd0, 1, 0, 2'd2, 0, 0, 0);
        add(32'h148, enc_r(5'd1, 5'd2, 5'd18, fn_addu), 5'd18, 0, 0, 2'd0, 0, 0, 0);
        add(32'h14c, enc_r(5'd1, 5'd2, 5'd19, fn_addu), 5'd19, 0, 0, 2'd0, 0, 0, 0);
        add(32'h150, enc_r(5'd1, 5'd2, 5'd20, fn_addu), 5'd20, 0, 0, 2'd0, 0, 0, 0);
        add(32'h200, enc_r(5'd1, 5'd2, 5'd3, fn_addu), 5'd3, 0, 0, 2'd0, 0, 0, 0);
        add(32'h204, enc_i(op_ori, 5'd6, 5'd5, 16'd1), 5'd5, 0, 0, 2'd0, 0, 0, 0);
        add(32'h208, {op_jal, 26'h80}, 5'd31, 0, 1, 2'd0, 0, 0, 0);
        add(32'h20c, {op_cop0, cop0_mf, 5'd9, 5'd12, 11'd0}, 5'd9, 1, 0, 2'd0, 0, 0, 0);
        add(32'h210, enc_r(5'd1, 5'd2, 5'd1, fn_addu), 5'd1, 0, 0, 2'd0, 0, 0, 0);
        add(32'h214, enc_r(5'd3, 5'd4, 5'd2, fn_addu), 5'd2, 0, 0, 2'd0, 0, 0, 0);
        add(32'h218, enc_r(5'd5, 5'd6, 5'd4, fn_add), 5'd4, 1, 0, 2'd0, 0, 0, 0);
        add(32'h21c, enc_r(5'd1, 5'd2, 5'd21, fn_addu), 5'd21, 0, 0, 2'd0, 0, 0, 0);
        add(32'h220, enc_r(5'd1, 5'd2, 5'd22, fn_addu), 5'd22, 0, 0, 2'd0, 0, 0, 0);
        cycle_limit = tbl.size() * 8 + 50;

        repeat (5) @(posedge clk);
        #2;
        rst = 1'b0;
        // each block ends with a lone entry that the flush clears
        run_phase(0, 20);
        run_phase(21, 29);
        repeat (4) @(posedge clk);
        $display("Simulation finished: PASS");
        $finish;
    end

endmodule

// ==== test/issue_properties.sv ====
module issue_properties (
    input logic clk,
    input logic rst,
    input logic stall,
    input logic flush,
    input logic pop_1,
    input logic pop_2
);
    timeunit 1ns;
    timeprecision 100ps;

    // second pop only together with the first
    pop_order: assert property (@(posedge clk) disable iff (rst) pop_2 |-> pop_1)
        else $error("pop_2 without pop_1");

    no_pop_in_stall: assert property (@(posedge clk) disable iff (rst)
        (stall || flush) |-> !(pop_1 || pop_2))
        else $error("pop during stall or flush");

endmodule

bind issue_ctrl issue_properties u_props (.*);

// ==== rtl/issue_top.sv ====
module issue_top import issue_pkg::*; (
    input  logic              clk,
    input  logic              rst,
    input  logic              stall,
    input  logic              flush,
    input  logic              push,
    input  logic [addr_w-1:0] push_pc,
    input  logic [inst_w-1:0] push_inst,
    input  logic              push_pred_taken,
    input  logic [addr_w-1:0] push_pred_target,
    input  logic              push_refill,
    input  logic              push_invalid,
    output logic              full,
    output logic              out_valid_1,
    output logic [addr_w-1:0] out_pc_1,
    output logic [inst_w-1:0] out_inst_1,
    output logic              out_w_ena_1,
    output logic [reg_w-1:0]  out_w_dst_1,
    output logic              out_in_ds_1,
    output logic [exc_w-1:0]  out_exc_1,
    output logic              out_refetch_1,
    output logic              out_valid_2,
    output logic [addr_w-1:0] out_pc_2,
    output logic [inst_w-1:0] out_inst_2,
    output logic              out_w_ena_2,
    output logic [reg_w-1:0]  out_w_dst_2,
    output logic              out_in_ds_2,
    output logic [exc_w-1:0]  out_exc_2,
    output logic              out_refetch_2
);

    logic [entry_w-1:0] head_data_1, head_data_2;
    logic               head_ok_1, head_ok_2;
    logic               pop_1, pop_2;

    logic               sel_valid_1, sel_w_ena_1, sel_in_ds_1, sel_refetch_1;
    logic [addr_w-1:0]  sel_pc_1;
    logic [inst_w-1:0]  sel_inst_1;
    logic [reg_w-1:0]   sel_w_dst_1;
    logic [exc_w-1:0]   sel_exc_1;

    logic               sel_valid_2, sel_w_ena_2, sel_in_ds_2, sel_refetch_2;
    logic [addr_w-1:0]  sel_pc_2;
    logic [inst_w-1:0]  sel_inst_2;
    logic [reg_w-1:0]   sel_w_dst_2;
    logic [exc_w-1:0]   sel_exc_2;

    // port names line up across the three blocks
    inst_queue u_queue (.*);

    issue_ctrl u_ctrl (.*);

    issue_reg u_reg (.*);

endmodule

// ==== rtl/issue_reg.sv ====
module issue_reg import issue_pkg::*; (
    input  logic              clk,
    input  logic              rst,
    input  logic              stall,
    input  logic              flush,
    input  logic              sel_valid_1,
    input  logic [addr_w-1:0] sel_pc_1,
    input  logic [inst_w-1:0] sel_inst_1,
    input  logic              sel_w_ena_1,
    input  logic [reg_w-1:0]  sel_w_dst_1,
    input  logic              sel_in_ds_1,
    input  logic [exc_w-1:0]  sel_exc_1,
    input  logic              sel_refetch_1,
    input  logic              sel_valid_2,
    input  logic [addr_w-1:0] sel_pc_2,
    input  logic [inst_w-1:0] sel_inst_2,
    input  logic              sel_w_ena_2,
    input  logic [reg_w-1:0]  sel_w_dst_2,
    input  logic              sel_in_ds_2,
    input  logic [exc_w-1:0]  sel_exc_2,
    input  logic              sel_refetch_2,
    output logic              out_valid_1,
    output logic [addr_w-1:0] out_pc_1,
    output logic [inst_w-1:0] out_inst_1,
    output logic              out_w_ena_1,
    output logic [reg_w-1:0]  out_w_dst_1,
    output logic              out_in_ds_1,
    output logic [exc_w-1:0]  out_exc_1,
    output logic              out_refetch_1,
    output logic              out_valid_2,
    output logic [addr_w-1:0] out_pc_2,
    output logic [inst_w-1:0] out_inst_2,
    output logic              out_w_ena_2,
    output logic [reg_w-1:0]  out_w_dst_2,
    output logic              out_in_ds_2,
    output logic [exc_w-1:0]  out_exc_2,
    output logic              out_refetch_2
);

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            out_valid_1 <= 1'b0;
            out_valid_2 <= 1'b0;
        end else if (!stall) begin
            out_valid_1 <= sel_valid_1;
            out_valid_2 <= sel_valid_2;
        end
    end

    // payload follows the valids, held under stall
    always_ff @(posedge clk) begin
        if (!stall) begin
            out_pc_1 <= sel_pc_1;
            out_inst_1 <= sel_inst_1;
            out_w_ena_1 <= sel_w_ena_1;
            out_w_dst_1 <= sel_w_dst_1;
            out_in_ds_1 <= sel_in_ds_1;
            out_exc_1 <= sel_exc_1;
            out_refetch_1 <= sel_refetch_1;
            out_pc_2 <= sel_pc_2;
            out_inst_2 <= sel_inst_2;
            out_w_ena_2 <= sel_w_ena_2;
            out_w_dst_2 <= sel_w_dst_2;
            out_in_ds_2 <= sel_in_ds_2;
            out_exc_2 <= sel_exc_2;
            out_refetch_2 <= sel_refetch_2;
        end
    end

endmodule

// ==== rtl/issue_ctrl.sv ====
module issue_ctrl import issue_pkg::*; (
    input  logic               clk,
    input  logic               rst,
    input  logic               stall,
    input  logic               flush,
    input  logic               head_ok_1,
    input  logic               head_ok_2,
    input  logic [entry_w-1:0] head_data_1,
    input  logic [entry_w-1:0] head_data_2,
    output logic               pop_1,
    output logic               pop_2,
    output logic               sel_valid_1,
    output logic [addr_w-1:0]  sel_pc_1,
    output logic [inst_w-1:0]  sel_inst_1,
    output logic               sel_w_ena_1,
    output logic [reg_w-1:0]   sel_w_dst_1,
    output logic               sel_in_ds_1,
    output logic [exc_w-1:0]   sel_exc_1,
    output logic               sel_refetch_1,
    output logic               sel_valid_2,
    output logic [addr_w-1:0]  sel_pc_2,
    output logic [inst_w-1:0]  sel_inst_2,
    output logic               sel_w_ena_2,
    output logic [reg_w-1:0]   sel_w_dst_2,
    output logic               sel_in_ds_2,
    output logic [exc_w-1:0]   sel_exc_2,
    output logic               sel_refetch_2
);

    logic [reg_w-1:0] rs_2, rt_2;
    logic br_1, jimm_1, jr_1, tlbp_1, tlbr_1, tlbwi_1, ri_1;
    logic br_2, jimm_2, jr_2, ls_2, mul_2, hilo_2, cop0_2;
    logic cache_2, ov_2, ri_2;
    logic jmp_1, jmp_2, raw, adel_1, adel_2, block_2;
    logic in_ds, refetch;

    function automatic logic [exc_w-1:0] exc_code(input logic adel, input logic refill,
                                                   input logic invalid, input logic ri);
        if (adel) return exc_adel;
        if (refill) return exc_tlb_refill;
        if (invalid) return exc_tlb_invalid;
        if (ri) return exc_ri;
        return exc_none;
    endfunction

    inst_decode dec_1 (
        .inst(sel_inst_1), .rs(), .rt(), .w_reg_ena(sel_w_ena_1), .w_reg_dst(sel_w_dst_1),
        .is_branch(br_1), .is_j_imme(jimm_1), .is_jr(jr_1), .is_ls(), .is_mul(),
        .is_hilo(), .is_cop0(), .is_tlbp(tlbp_1), .is_tlbr(tlbr_1), .is_tlbwi(tlbwi_1),
        .is_cache(), .is_check_ov(), .is_ri(ri_1)
    );

    inst_decode dec_2 (
        .inst(sel_inst_2), .rs(rs_2), .rt(rt_2), .w_reg_ena(sel_w_ena_2),
        .w_reg_dst(sel_w_dst_2), .is_branch(br_2), .is_j_imme(jimm_2), .is_jr(jr_2),
        .is_ls(ls_2), .is_mul(mul_2), .is_hilo(hilo_2), .is_cop0(cop0_2), .is_tlbp(),
        .is_tlbr(), .is_tlbwi(), .is_cache(cache_2), .is_check_ov(ov_2),
        .is_ri(ri_2)
    );

    assign sel_pc_1 = head_data_1[pc_lo +: addr_w];
    assign sel_inst_1 = head_data_1[inst_lo +: inst_w];
    assign sel_pc_2 = head_data_2[pc_lo +: addr_w];
    assign sel_inst_2 = head_data_2[inst_lo +: inst_w];

    assign jmp_1 = br_1 | jimm_1 | jr_1;
    assign jmp_2 = br_2 | jimm_2 | jr_2;
    assign adel_1 = sel_pc_1[1:0] != 2'b00;
    assign adel_2 = sel_pc_2[1:0] != 2'b00;

    // slot 2 reads (or rewrites) what slot 1 writes
    assign raw = sel_w_ena_1 & (((sel_w_dst_1 == rs_2) & (rs_2 != '0))
                              | ((sel_w_dst_1 == rt_2) & (rt_2 != '0)));

    assign block_2 = in_ds | raw | jmp_2 | hilo_2 | cop0_2 | ls_2 | ri_2 | ov_2 | adel_2
                   | head_data_2[pos_refill] | head_data_2[pos_invalid] | mul_2 | cache_2
                   | tlbp_1 | tlbr_1 | tlbwi_1;

    // a lone entry waits for a second one
    always_comb begin
        pop_1 = 1'b0;
        pop_2 = 1'b0;
        if (!stall && !flush && head_ok_1 && head_ok_2) begin
            pop_1 = 1'b1;
            pop_2 = ~block_2;
        end
    end

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            in_ds <= 1'b0;
            refetch <= 1'b0;
        end else begin
            // held until the delay slot itself issues
            in_ds <= in_ds ? ~pop_1 : (pop_1 & jmp_1 & ~pop_2);
            if (pop_1 & (tlbr_1 | tlbwi_1)) begin
                refetch <= 1'b1;
            end
        end
    end

    assign sel_valid_1 = pop_1;
    assign sel_in_ds_1 = in_ds;
    assign sel_exc_1 = exc_code(adel_1, head_data_1[pos_refill], head_data_1[pos_invalid], ri_1);
    assign sel_refetch_1 = refetch;

    assign sel_valid_2 = pop_2;
    assign sel_in_ds_2 = jmp_1 & pop_2;
    assign sel_exc_2 = exc_code(adel_2, head_data_2[pos_refill], head_data_2[pos_invalid], ri_2);
    assign sel_refetch_2 = refetch;

endmodule

// ==== rtl/inst_decode.sv ====
module inst_decode import issue_pkg::*; (
    input  logic [inst_w-1:0] inst,
    output logic [reg_w-1:0]  rs,
    output logic [reg_w-1:0]  rt,
    output logic              w_reg_ena,
    output logic [reg_w-1:0]  w_reg_dst,
    output logic              is_branch,
    output logic              is_j_imme,
    output logic              is_jr,
    output logic              is_ls,
    output logic              is_mul,
    output logic              is_hilo,
    output logic              is_cop0,
    output logic              is_tlbp,
    output logic              is_tlbr,
    output logic              is_tlbwi,
    output logic              is_cache,
    output logic              is_check_ov,
    output logic              is_ri
);

    logic [5:0]       op;
    logic [5:0]       fn;
    logic [reg_w-1:0] rd;
    logic             special;
    logic             cop0;
    logic             i_addu, i_subu, i_add, i_jr, i_mult, i_mfhi, i_mflo;
    logic             i_addi, i_addiu, i_ori, i_lui, i_lw, i_sw;
    logic             i_beq, i_bne, i_j, i_jal;
    logic             i_mfc0, i_mtc0, i_tlbp, i_tlbr, i_tlbwi, i_cache;
    logic             wr_rd, wr_rt, wr_ra, legal;

    assign op = inst[31:26];
    assign fn = inst[5:0];
    assign rs = inst[25:21];
    assign rt = inst[20:16];
    assign rd = inst[15:11];

    assign special = op == op_special;
    assign cop0 = op == op_cop0;

    assign i_addu = special & (fn == fn_addu);
    assign i_subu = special & (fn == fn_subu);
    assign i_add = special & (fn == fn_add);
    assign i_jr = special & (fn == fn_jr);
    assign i_mult = special & (fn == fn_mult);
    assign i_mfhi = special & (fn == fn_mfhi);
    assign i_mflo = special & (fn == fn_mflo);

    assign i_addi = op == op_addi;
    assign i_addiu = op == op_addiu;
    assign i_ori = op == op_ori;
    assign i_lui = op == op_lui;
    assign i_lw = op == op_lw;
    assign i_sw = op == op_sw;
    assign i_beq = op == op_beq;
    assign i_bne = op == op_bne;
    assign i_j = op == op_j;
    assign i_jal = op == op_jal;
    assign i_cache = op == op_cache;

    assign i_mfc0 = cop0 & (rs == cop0_mf);
    assign i_mtc0 = cop0 & (rs == cop0_mt);
    // tlb ops live under CO=1
    assign i_tlbp = cop0 & inst[25] & (fn == fn_tlbp);
    assign i_tlbr = cop0 & inst[25] & (fn == fn_tlbr);
    assign i_tlbwi = cop0 & inst[25] & (fn == fn_tlbwi);

    assign wr_rd = i_addu | i_subu | i_add | i_mfhi | i_mflo;
    assign wr_rt = i_addi | i_addiu | i_ori | i_lui | i_lw | i_mfc0;
    assign wr_ra = i_jal;

    assign w_reg_dst = wr_ra ? {reg_w{1'b1}} : (wr_rd ? rd : rt);
    // r0 as destination is no write
    assign w_reg_ena = (wr_rd | wr_rt | wr_ra) & (w_reg_dst != '0);

    assign is_branch = i_beq | i_bne;
    assign is_j_imme = i_j | i_jal;
    assign is_jr = i_jr;
    assign is_ls = i_lw | i_sw;
    assign is_mul = i_mult;
    assign is_hilo = i_mfhi | i_mflo;
    assign is_cop0 = i_mfc0 | i_mtc0 | i_tlbp | i_tlbr | i_tlbwi;
    assign is_tlbp = i_tlbp;
    assign is_tlbr = i_tlbr;
    assign is_tlbwi = i_tlbwi;
    assign is_cache = i_cache;
    assign is_check_ov = i_add | i_addi;

    assign legal = wr_rd | wr_rt | wr_ra | i_jr | i_mult | i_sw | is_branch | i_j
                 | i_mtc0 | i_tlbp | i_tlbr | i_tlbwi | i_cache;
    assign is_ri = ~legal;

endmodule

// ==== rtl/inst_queue.sv ====
module inst_queue import issue_pkg::*; (
    input  logic               clk,
    input  logic               rst,
    input  logic               flush,
    input  logic               push,
    input  logic [addr_w-1:0]  push_pc,
    input  logic [inst_w-1:0]  push_inst,
    input  logic               push_pred_taken,
    input  logic [addr_w-1:0]  push_pred_target,
    input  logic               push_refill,
    input  logic               push_invalid,
    input  logic               pop_1,
    input  logic               pop_2,
    output logic               full,
    output logic               head_ok_1,
    output logic               head_ok_2,
    output logic [entry_w-1:0] head_data_1,
    output logic [entry_w-1:0] head_data_2
);

    logic [entry_w-1:0] mem [queue_depth];
    logic [entry_w-1:0] push_entry;
    logic [qptr_w-1:0]  rd_ptr;
    logic [qptr_w-1:0]  rd_ptr_2;
    logic [qptr_w-1:0]  wr_ptr;
    logic [qptr_w:0]    count;
    logic [qptr_w:0]    pop_cnt;
    logic               do_push;

    always_comb begin
        push_entry = '0;
        push_entry[pos_pred_taken] = push_pred_taken;
        push_entry[pos_pred_taken-1:pos_refill+1] = push_pred_target;
        push_entry[pos_refill] = push_refill;
        push_entry[pos_invalid] = push_invalid;
        push_entry[pc_lo +: addr_w] = push_pc;
        push_entry[inst_lo +: inst_w] = push_inst;
    end

    // a push while full is dropped
    assign do_push = push & ~full;
    assign pop_cnt = {{qptr_w{1'b0}}, pop_1} + {{qptr_w{1'b0}}, pop_2};

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            rd_ptr <= rd_ptr + pop_cnt[qptr_w-1:0];
            count <= count + {{qptr_w{1'b0}}, do_push} - pop_cnt;
        end
    end

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= push_entry;
        end
    end

    assign rd_ptr_2 = rd_ptr + 1'b1;

    assign full = count == (qptr_w + 1)'(queue_depth);
    assign head_ok_1 = count != '0;
    assign head_ok_2 = count >= (qptr_w + 1)'(2);
    assign head_data_1 = mem[rd_ptr];
    assign head_data_2 = mem[rd_ptr_2];

endmodule

// ==== rtl/issue_pkg.sv ====
package issue_pkg;

    localparam int addr_w = 32;
    localparam int inst_w = 32;
    localparam int reg_w = 5;
    localparam int exc_w = 3;

    localparam int queue_depth = 8;
    localparam int qptr_w = $clog2(queue_depth);

    // fetch packet layout
    localparam int entry_w = 99;
    localparam int pos_pred_taken = 98;
    localparam int pos_refill = 65;
    localparam int pos_invalid = 64;
    localparam int pc_lo = 32;
    localparam int inst_lo = 0;

    localparam logic [5:0] op_special = 6'b000000;
    localparam logic [5:0] op_j = 6'b000010;
    localparam logic [5:0] op_jal = 6'b000011;
    localparam logic [5:0] op_beq = 6'b000100;
    localparam logic [5:0] op_bne = 6'b000101;
    localparam logic [5:0] op_addi = 6'b001000;
    localparam logic [5:0] op_addiu = 6'b001001;
    localparam logic [5:0] op_ori = 6'b001101;
    localparam logic [5:0] op_lui = 6'b001111;
    localparam logic [5:0] op_cop0 = 6'b010000;
    localparam logic [5:0] op_lw = 6'b100011;
    localparam logic [5:0] op_sw = 6'b101011;
    localparam logic [5:0] op_cache = 6'b101111;

    localparam logic [5:0] fn_jr = 6'b001000;
    localparam logic [5:0] fn_mfhi = 6'b010000;
    localparam logic [5:0] fn_mflo = 6'b010010;
    localparam logic [5:0] fn_mult = 6'b011000;
    localparam logic [5:0] fn_add = 6'b100000;
    localparam logic [5:0] fn_addu = 6'b100001;
    localparam logic [5:0] fn_subu = 6'b100011;

    // cop0 rs field, then tlb function codes (CO bit set)
    localparam logic [4:0] cop0_mf = 5'b00000;
    localparam logic [4:0] cop0_mt = 5'b00100;
    localparam logic [5:0] fn_tlbr = 6'b000001;
    localparam logic [5:0] fn_tlbwi = 6'b000010;
    localparam logic [5:0] fn_tlbp = 6'b001000;

    // address error outranks the tlb faults and reserved instruction
    localparam logic [exc_w-1:0] exc_none = 3'd0;
    localparam logic [exc_w-1:0] exc_adel = 3'd1;
    localparam logic [exc_w-1:0] exc_tlb_refill = 3'd2;
    localparam logic [exc_w-1:0] exc_tlb_invalid = 3'd3;
    localparam logic [exc_w-1:0] exc_ri = 3'd4;

endpackage
